//--- verilog/sounder_pkg.sv
// Channel sounder shared types, register map, PN tap table and LFSR helpers
package sounder_pkg;

   // Serial port word widths
   localparam int SADDR_W    = 7;
   localparam int SDATA_W    = 32;
   // Converter widths
   localparam int DAC_W      = 14;
   localparam int ADC_W      = 12;
   // Correlator
   localparam int ACC_W      = 24;
   localparam int PN_MAX_DEG = 10;
   localparam int LAG_W      = 10;

   // Register addresses seen on the serial port
   typedef enum logic [SADDR_W-1:0] {
      REG_MODE   = 7'd0,
      REG_DEGREE = 7'd1,
      REG_RATE   = 7'd2,
      REG_AMPL   = 7'd3
   } reg_addr_e;

   typedef struct packed {
      logic        tx_en;
      logic        rx_en;
      logic [3:0]  degree;
      logic [15:0] rate;
      logic [12:0] ampl;
   } sounder_cfg_t;

   // Payload of one serial write, qualified by a separate strobe
   typedef struct packed {
      logic [SADDR_W-1:0] addr;
      logic [SDATA_W-1:0] data;
   } sreg_wr_t;

   typedef struct packed {
      logic [LAG_W-1:0]        lag;
      logic signed [ACC_W-1:0] acc_i;
      logic signed [ACC_W-1:0] acc_q;
   } imp_tap_t;

   // Feedback masks, bit n-1 set for tap n of the primitive polynomial
   localparam logic [PN_MAX_DEG-1:0] pn_taps [4:PN_MAX_DEG] = '{
      10'h00c,  // x^4 + x^3 + 1
      10'h014,  // x^5 + x^3 + 1
      10'h030,  // x^6 + x^5 + 1
      10'h060,  // x^7 + x^6 + 1
      10'h0b8,  // x^8 + x^6 + x^5 + x^4 + 1
      10'h110,  // x^9 + x^5 + 1
      10'h240   // x^10 + x^7 + 1
   };

   // Ones in the low degree bits, also the code period 2^degree-1
   function automatic logic [PN_MAX_DEG-1:0] pn_mask(input logic [3:0] degree);
      logic [PN_MAX_DEG:0] full;
      full         = '0;
      full[degree] = 1'b1;
      return PN_MAX_DEG'(full - 1'b1);
   endfunction

   // One Fibonacci step, new bit enters at the bottom
   function automatic logic [PN_MAX_DEG-1:0] pn_next(input logic [PN_MAX_DEG-1:0] state,
                                                      input logic [3:0] degree);
      logic fb;
      fb = ^(state & pn_taps[degree]);
      return {state[PN_MAX_DEG-2:0], fb};
   endfunction

   // Current chip is the oldest stage of the active length
   function automatic logic pn_chip(input logic [PN_MAX_DEG-1:0] state,
                                    input logic [3:0] degree);
      return state[degree - 4'd1];
   endfunction

endpackage

//--- verilog/serial_io.sv
// Serial port slave that turns 40-bit sclk/sdi/sen frames into register writes
module serial_io (
   input  logic                  clk_i,
   input  logic                  arst_n_i,
   input  logic                  sclk_i,
   input  logic                  sdi_i,
   input  logic                  sen_i,
   output logic                  wr_stb_o,
   output sounder_pkg::sreg_wr_t wr_o
);
   import sounder_pkg::*;

   localparam int FRAME_BITS = 8 + SDATA_W;

   // Two flop synchronizers, third sclk/sen flop for edge detection
   logic [1:0] sclk_sync, sdi_sync, sen_sync;
   logic       sclk_d, sen_d;
   logic       sclk_rise, sen_fall;
   logic [5:0] bit_cnt;
   logic [FRAME_BITS-1:0] shift;
   logic       frame_ok;
   logic [1:0] ok_pipe;

   assign sclk_rise = sclk_sync[1] & ~sclk_d;
   assign sen_fall  = sen_d & ~sen_sync[1];
   assign frame_ok  = sen_fall && (bit_cnt == 6'(FRAME_BITS));

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         sclk_sync <= '0;
         sdi_sync  <= '0;
         sen_sync  <= '0;
         sclk_d    <= 1'b0;
         sen_d     <= 1'b0;
      end else begin
         sclk_sync <= {sclk_sync[0], sclk_i};
         sdi_sync  <= {sdi_sync[0], sdi_i};
         sen_sync  <= {sen_sync[0], sen_i};
         sclk_d    <= sclk_sync[1];
         sen_d     <= sen_sync[1];
      end
   end

   // Bit counter saturates so long frames never alias to 40
   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         bit_cnt <= '0;
      end else if (!sen_sync[1]) begin
         bit_cnt <= '0;
      end else if (sclk_rise && bit_cnt != 6'h3f) begin
         bit_cnt <= bit_cnt + 6'd1;
      end
   end

   // MSB first shift register
   always_ff @(posedge clk_i) begin
      if (sen_sync[1] && sclk_rise) begin
         shift <= {shift[FRAME_BITS-2:0], sdi_sync[1]};
      end
   end

   // Address top bit is dropped
   always_ff @(posedge clk_i) begin
      if (frame_ok) begin
         wr_o.addr <= shift[SDATA_W +: SADDR_W];
         wr_o.data <= shift[SDATA_W-1:0];
      end
   end

   // Strobe lands three clocks after the sen fall is seen
   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         ok_pipe  <= '0;
         wr_stb_o <= 1'b0;
      end else begin
         ok_pipe  <= {ok_pipe[0], frame_ok};
         wr_stb_o <= ok_pipe[1];
      end
   end

   // One write per frame, sen must drop and rise between writes
   assert property (@(posedge clk_i) disable iff (!arst_n_i) wr_stb_o |=> !wr_stb_o);

endmodule

//--- verilog/sounder_ctrl.sv
// Sounder control registers and sample strobe divider for transmit and receive
module sounder_ctrl (
   input  logic                      clk_i,
   input  logic                      arst_n_i,
   input  logic                      wr_stb_i,
   input  sounder_pkg::sreg_wr_t     wr_i,
   output sounder_pkg::sounder_cfg_t cfg_o,
   output logic                      code_restart_o,
   output logic                      tx_stb_o,
   output logic                      rx_stb_o
);
   import sounder_pkg::*;

   logic [3:0]  degree_clamped;
   logic [15:0] div_cnt;
   logic        tick;

   // Out of range degrees pinned to the table limits
   always_comb begin
      if (wr_i.data < 32'd4) begin
         degree_clamped = 4'd4;
      end else if (wr_i.data > 32'(PN_MAX_DEG)) begin
         degree_clamped = 4'(PN_MAX_DEG);
      end else begin
         degree_clamped = wr_i.data[3:0];
      end
   end

   // Register file
   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         cfg_o          <= '{tx_en: 1'b0, rx_en: 1'b0, degree: 4'd4, rate: '0, ampl: '0};
         code_restart_o <= 1'b0;
      end else begin
         code_restart_o <= 1'b0;
         if (wr_stb_i) begin
            case (reg_addr_e'(wr_i.addr))
               REG_MODE: begin
                  cfg_o.tx_en <= wr_i.data[0];
                  cfg_o.rx_en <= wr_i.data[1];
               end
               REG_DEGREE: begin
                  cfg_o.degree   <= degree_clamped;
                  code_restart_o <= 1'b1;
               end
               REG_RATE: cfg_o.rate <= wr_i.data[15:0];
               REG_AMPL: cfg_o.ampl <= wr_i.data[12:0];
               // Unknown addresses are ignored
               default: ;
            endcase
         end
      end
   end

   // Divider period is rate+1, any write restarts it
   assign tick = (div_cnt == cfg_o.rate) && !wr_stb_i;

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         div_cnt <= '0;
      end else if (wr_stb_i || tick) begin
         div_cnt <= '0;
      end else begin
         div_cnt <= div_cnt + 16'd1;
      end
   end

   // Both strobes share the tick so tx and rx stay chip aligned
   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         tx_stb_o <= 1'b0;
         rx_stb_o <= 1'b0;
      end else begin
         tx_stb_o <= tick & cfg_o.tx_en;
         rx_stb_o <= tick & cfg_o.rx_en;
      end
   end

   assert property (@(posedge clk_i) disable iff (!arst_n_i)
      wr_stb_i |=> cfg_o.degree inside {[4:PN_MAX_DEG]});

endmodule

//--- verilog/pn_transmitter.sv
// PN transmitter producing +/-ampl I samples from a maximal-length sequence
module pn_transmitter (
   input  logic                                   clk_i,
   input  logic                                   arst_n_i,
   input  logic                                   code_restart_i,
   input  logic                                   tx_stb_i,
   input  sounder_pkg::sounder_cfg_t              cfg_i,
   output logic signed [sounder_pkg::DAC_W-1:0]   tx_i_o,
   output logic signed [sounder_pkg::DAC_W-1:0]   tx_q_o
);
   import sounder_pkg::*;

   logic [PN_MAX_DEG-1:0]   lfsr;
   logic signed [DAC_W-1:0] amp_pos;
   logic signed [DAC_W-1:0] amp_neg;

   assign amp_pos = signed'({1'b0, cfg_i.ampl});
   assign amp_neg = -amp_pos;

   // Code generator, all ones seed on degree change
   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         lfsr <= '1;
      end else if (code_restart_i) begin
         lfsr <= '1;
      end else if (tx_stb_i) begin
         lfsr <= pn_next(lfsr, cfg_i.degree);
      end
   end

   // Chip 1 maps to +ampl, chip 0 to -ampl
   always_ff @(posedge clk_i) begin
      if (tx_stb_i && !code_restart_i) begin
         tx_i_o <= pn_chip(lfsr, cfg_i.degree) ? amp_pos : amp_neg;
      end
   end

   // Real valued probe, Q rail unused
   assign tx_q_o = '0;

   // Lockup state would stop the code
   assert property (@(posedge clk_i) disable iff (!arst_n_i)
      !code_restart_i |-> (lfsr & pn_mask(cfg_i.degree)) != '0);

endmodule

//--- verilog/dac_interface.sv
// DAC interface that interleaves I and Q words and flags the I word with sync
module dac_interface (
   input  logic                                 clk_i,
   input  logic                                 arst_n_i,
   input  logic                                 ena_i,
   input  logic                                 strobe_i,
   input  logic signed [sounder_pkg::DAC_W-1:0] tx_i_i,
   input  logic signed [sounder_pkg::DAC_W-1:0] tx_q_i,
   output logic [sounder_pkg::DAC_W-1:0]        tx_data_o,
   output logic                                 tx_sync_o
);
   import sounder_pkg::*;

   typedef enum logic {IDLE, SEND_Q} dac_state_e;

   dac_state_e state;
   // Samples settle one clock after the strobe
   logic       strobe_d;

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         strobe_d  <= 1'b0;
         state     <= IDLE;
         tx_data_o <= '0;
         tx_sync_o <= 1'b0;
      end else if (!ena_i) begin
         strobe_d  <= 1'b0;
         state     <= IDLE;
         tx_data_o <= '0;
         tx_sync_o <= 1'b0;
      end else begin
         strobe_d  <= strobe_i;
         tx_sync_o <= 1'b0;
         case (state)
            IDLE: begin
               // Q word stays on the bus between samples
               if (strobe_d) begin
                  tx_data_o <= tx_i_i;
                  tx_sync_o <= 1'b1;
                  state     <= SEND_Q;
               end
            end
            SEND_Q: begin
               tx_data_o <= tx_q_i;
               state     <= IDLE;
            end
            default: state <= IDLE;
         endcase
      end
   end

   // Every I word is followed by a Q word
   assert property (@(posedge clk_i) disable iff (!arst_n_i) tx_sync_o |=> !tx_sync_o);

endmodule

//--- verilog/pn_correlator.sv
// Sliding PN correlator emitting one impulse response tap per code period
module pn_correlator (
   input  logic                                 clk_i,
   input  logic                                 arst_n_i,
   input  logic                                 code_restart_i,
   input  logic                                 rx_stb_i,
   input  logic                                 tap_ack_i,
   input  logic                                 clear_status_i,
   input  sounder_pkg::sounder_cfg_t            cfg_i,
   input  logic signed [sounder_pkg::ADC_W-1:0] adc_i_i,
   input  logic signed [sounder_pkg::ADC_W-1:0] adc_q_i,
   output logic                                 tap_req_o,
   output logic                                 rx_overrun_o,
   output sounder_pkg::imp_tap_t                tap_o
);
   import sounder_pkg::*;

   typedef enum logic [1:0] {IDLE, REQ, WAIT_ACK_LOW} hs_state_e;

   hs_state_e               hs_state;
   logic [PN_MAX_DEG-1:0]   replica;
   logic [LAG_W-1:0]        chip_cnt;
   logic [LAG_W-1:0]        lag;
   logic [LAG_W-1:0]        last_idx;
   logic                    chip;
   logic                    period_done;
   logic signed [ACC_W-1:0] acc_i, acc_q;
   logic signed [ACC_W-1:0] sum_i, sum_q;

   // N-1 is both the last chip index and the last lag
   assign last_idx    = LAG_W'(pn_mask(cfg_i.degree)) - 1'b1;
   assign chip        = pn_chip(replica, cfg_i.degree);
   assign period_done = rx_stb_i && !code_restart_i && (chip_cnt == last_idx);

   // Despread the current sample
   assign sum_i = chip ? acc_i + ACC_W'(adc_i_i) : acc_i - ACC_W'(adc_i_i);
   assign sum_q = chip ? acc_q + ACC_W'(adc_q_i) : acc_q - ACC_W'(adc_q_i);

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         replica  <= '1;
         chip_cnt <= '0;
         lag      <= '0;
         acc_i    <= '0;
         acc_q    <= '0;
      end else if (code_restart_i) begin
         replica  <= '1;
         chip_cnt <= '0;
         lag      <= '0;
         acc_i    <= '0;
         acc_q    <= '0;
      end else if (rx_stb_i) begin
         if (chip_cnt == last_idx) begin
            // Replica holds here, next period slides by one chip
            chip_cnt <= '0;
            acc_i    <= '0;
            acc_q    <= '0;
            lag      <= (lag == last_idx) ? '0 : lag + 1'b1;
         end else begin
            replica  <= pn_next(replica, cfg_i.degree);
            chip_cnt <= chip_cnt + 1'b1;
            acc_i    <= sum_i;
            acc_q    <= sum_q;
         end
      end
   end

   // Tap register only loads with no transfer open
   always_ff @(posedge clk_i) begin
      if (period_done && hs_state == IDLE) begin
         tap_o.lag   <= lag;
         tap_o.acc_i <= sum_i;
         tap_o.acc_q <= sum_q;
      end
   end

   // Four phase req/ack
   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         hs_state <= IDLE;
      end else begin
         case (hs_state)
            IDLE:         if (period_done) hs_state <= REQ;
            REQ:          if (tap_ack_i) hs_state <= WAIT_ACK_LOW;
            WAIT_ACK_LOW: if (!tap_ack_i) hs_state <= IDLE;
            default:      hs_state <= IDLE;
         endcase
      end
   end

   assign tap_req_o = (hs_state == REQ);

   // Sticky until software clears it, a new loss wins over the clear
   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         rx_overrun_o <= 1'b0;
      end else if (period_done && hs_state != IDLE) begin
         rx_overrun_o <= 1'b1;
      end else if (clear_status_i) begin
         rx_overrun_o <= 1'b0;
      end
   end

   assert property (@(posedge clk_i) disable iff (!arst_n_i)
      tap_req_o && $past(tap_req_o) |-> tap_o == $past(tap_o));

endmodule

//--- verilog/usrp_sounder.sv
// Channel sounder top tying the serial port, control, PN transmit and receive paths
module usrp_sounder (
   input  logic                          clk_i,
   input  logic                          arst_n_i,
   input  logic                          sclk_i,
   input  logic                          sdi_i,
   input  logic                          sen_i,
   input  logic                          clear_status_i,
   input  logic [sounder_pkg::ADC_W-1:0] rx_a_a_i,
   input  logic [sounder_pkg::ADC_W-1:0] rx_b_a_i,
   output logic [sounder_pkg::DAC_W-1:0] tx_a_o,
   output logic                          txsync_a_o,
   output logic                          tap_req_o,
   input  logic                          tap_ack_i,
   output sounder_pkg::imp_tap_t         tap_o,
   output logic                          rx_overrun_o
);
   import sounder_pkg::*;

   sreg_wr_t                serial_wr;
   logic                    serial_stb;
   sounder_cfg_t            cfg;
   logic                    code_restart;
   logic                    tx_stb, rx_stb;
   logic signed [DAC_W-1:0] tx_i, tx_q;

   serial_io u_serial_io (
      .clk_i(clk_i), .arst_n_i(arst_n_i),
      .sclk_i(sclk_i), .sdi_i(sdi_i), .sen_i(sen_i),
      .wr_stb_o(serial_stb), .wr_o(serial_wr)
   );

   sounder_ctrl u_ctrl (
      .clk_i(clk_i), .arst_n_i(arst_n_i),
      .wr_stb_i(serial_stb), .wr_i(serial_wr),
      .cfg_o(cfg), .code_restart_o(code_restart),
      .tx_stb_o(tx_stb), .rx_stb_o(rx_stb)
   );

   // Transmit side
   pn_transmitter u_tx (
      .clk_i(clk_i), .arst_n_i(arst_n_i),
      .code_restart_i(code_restart), .tx_stb_i(tx_stb), .cfg_i(cfg),
      .tx_i_o(tx_i), .tx_q_o(tx_q)
   );

   dac_interface u_dac (
      .clk_i(clk_i), .arst_n_i(arst_n_i),
      .ena_i(cfg.tx_en), .strobe_i(tx_stb),
      .tx_i_i(tx_i), .tx_q_i(tx_q),
      .tx_data_o(tx_a_o), .tx_sync_o(txsync_a_o)
   );

   // Receive side, first ADC pair only
   pn_correlator u_corr (
      .clk_i(clk_i), .arst_n_i(arst_n_i),
      .code_restart_i(code_restart), .rx_stb_i(rx_stb),
      .tap_ack_i(tap_ack_i), .clear_status_i(clear_status_i), .cfg_i(cfg),
      .adc_i_i(rx_a_a_i), .adc_q_i(rx_b_a_i),
      .tap_req_o(tap_req_o), .rx_overrun_o(rx_overrun_o), .tap_o(tap_o)
   );

endmodule

//--- tb/tb_usrp_sounder.sv
// Testbench for the channel sounder with a loopback channel model and a tap consumer
module tb_usrp_sounder;
   timeunit 1ns;
   timeprecision 1ps;
   import sounder_pkg::*;

   localparam int PERIOD_NS = 8;
   localparam int NV        = 4;
   localparam int NF        = 7;
   localparam int HIST_LEN  = 64;
   // Allowance for serial frames and reset on top of the per vector budget
   localparam int SETUP_CYC = 20000;

   logic clk_i, arst_n_i, sclk_i, sdi_i, sen_i, clear_status_i, tap_ack_i;
   logic [ADC_W-1:0] rx_a_a_i, rx_b_a_i;
   logic [DAC_W-1:0] tx_a_o;
   logic             txsync_a_o, tap_req_o, rx_overrun_o;
   imp_tap_t         tap_o;

   // Vector rows: degree rate ampl delay gain peak offpeak
   logic [31:0] vec_mem [0:NV*NF-1];
   imp_tap_t    tap_q[$];
   logic [ADC_W-1:0] hist [0:HIST_LEN-1];
   logic [31:0] rng;
   int  errors, chan_delay, chan_gain, cur_ampl, exp_peak, exp_off;
   bit  random_ack, hold_ack, check_ampl;
   logic req_d, ack_d, sync_d;
   imp_tap_t tap_d;

   usrp_sounder dut (
      .clk_i(clk_i), .arst_n_i(arst_n_i),
      .sclk_i(sclk_i), .sdi_i(sdi_i), .sen_i(sen_i), .clear_status_i(clear_status_i),
      .rx_a_a_i(rx_a_a_i), .rx_b_a_i(rx_b_a_i),
      .tx_a_o(tx_a_o), .txsync_a_o(txsync_a_o),
      .tap_req_o(tap_req_o), .tap_ack_i(tap_ack_i), .tap_o(tap_o),
      .rx_overrun_o(rx_overrun_o)
   );

   always #(PERIOD_NS/2) clk_i = ~clk_i;

   // Galois LFSR, taps 32 22 2 1
   function automatic logic [31:0] galois_step(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
   endfunction

   // Shifts out one frame MSB first, sclk slow enough for the synchronizers
   task automatic send_frame(input logic [39:0] bits, input int nbits);
      @(posedge clk_i);
      sen_i <= 1'b1;
      repeat (2) @(posedge clk_i);
      for (int i = 0; i < nbits; i++) begin
         sdi_i <= bits[39-i];
         repeat (3) @(posedge clk_i);
         sclk_i <= 1'b1;
         repeat (3) @(posedge clk_i);
         sclk_i <= 1'b0;
      end
      repeat (3) @(posedge clk_i);
      sen_i <= 1'b0;
      // Write lands a few clocks after sen falls
      repeat (10) @(posedge clk_i);
   endtask

   task automatic write_reg(input reg_addr_e addr, input logic [31:0] data);
      send_frame({1'b0, addr, data}, 40);
   endtask

   task automatic get_tap(output imp_tap_t t);
      while (tap_q.size() == 0) @(posedge clk_i);
      t = tap_q.pop_front();
   endtask

   // Lag D holds the peak, every other lag the m-sequence off-peak level
   task automatic check_tap(input imp_tap_t t, input int exp_lag, input bit check_vals);
      int exp_i;
      exp_i = (exp_lag == chan_delay) ? exp_peak : exp_off;
      assert (int'(t.lag) == exp_lag) else begin
         errors++;
         $display("ERROR %0t: tap lag %0d, expected %0d", $time, t.lag, exp_lag);
      end
      if (check_vals) begin
         assert (int'(t.acc_i) == exp_i) else begin
            errors++;
            $display("ERROR %0t: lag %0d acc_i %0d, expected %0d", $time, t.lag, t.acc_i, exp_i);
         end
         assert (t.acc_q == '0) else begin
            errors++;
            $display("ERROR %0t: lag %0d acc_q %0d, expected 0", $time, t.lag, t.acc_q);
         end
      end
   endtask

   // Channel model, delays the I words by D strobes and scales by the gain shift
   always @(posedge clk_i) begin : channel
      logic signed [DAC_W-1:0] word;
      if (txsync_a_o) begin
         word = tx_a_o;
         for (int m = HIST_LEN-1; m > 0; m--) hist[m] = hist[m-1];
         hist[0] = ADC_W'(word >>> chan_gain);
         rx_a_a_i <= hist[chan_delay-1];
      end
   end

   // Bus and handshake protocol monitor
   always @(posedge clk_i) begin
      if (arst_n_i) begin
         assert (!(sync_d && txsync_a_o)) else begin
            errors++;
            $display("ERROR %0t: sync high for two cycles", $time);
         end
         if (!txsync_a_o) begin
            assert (tx_a_o == '0) else begin
               errors++;
               $display("ERROR %0t: Q word %0h, expected 0", $time, tx_a_o);
            end
         end else if (check_ampl) begin
            assert (tx_a_o == DAC_W'(cur_ampl) || tx_a_o == DAC_W'(-cur_ampl)) else begin
               errors++;
               $display("ERROR %0t: I word %0h, expected +/-%0d", $time, tx_a_o, cur_ampl);
            end
         end
         if (req_d && tap_req_o) begin
            assert (tap_o == tap_d) else begin
               errors++;
               $display("ERROR %0t: tap changed while req high", $time);
            end
         end
         if (req_d && !tap_req_o) begin
            assert (ack_d) else begin
               errors++;
               $display("ERROR %0t: req dropped before ack", $time);
            end
         end
      end
      req_d  <= tap_req_o;
      ack_d  <= tap_ack_i;
      sync_d <= txsync_a_o;
      tap_d  <= tap_o;
   end

   // Tap consumer, optional random 0..15 cycle delay before ack
   initial begin : tap_consumer
      int wait_cyc;
      forever begin
         @(posedge clk_i);
         if (tap_req_o && !tap_ack_i) begin
            tap_q.push_back(tap_o);
            wait_cyc = 0;
            if (random_ack) begin
               for (int b = 0; b < 4; b++) begin
                  rng      = galois_step(rng);
                  wait_cyc = wait_cyc * 2 + int'(rng[0]);
               end
            end
            repeat (wait_cyc) @(posedge clk_i);
            while (hold_ack) @(posedge clk_i);
            tap_ack_i <= 1'b1;
            while (tap_req_o) @(posedge clk_i);
            tap_ack_i <= 1'b0;
         end
      end
   end

   // Watchdog budget from the vector lengths
   initial begin : watchdog
      int limit;
      #1;
      limit = SETUP_CYC;
      for (int v = 0; v < NV; v++) begin
         limit += (1 << vec_mem[v*NF]) * (1 << vec_mem[v*NF]) * (vec_mem[v*NF+1] + 1) * 2;
      end
      repeat (limit) @(posedge clk_i);
      $display("Timeout: the run did not finish within %0d clock cycles", limit);
      $display("FAIL: see errors above");
      $finish;
   end

   initial begin : main
      imp_tap_t t;
      int n, rate, next_lag, held_lag, hold_cyc;
      $readmemh("tb/sounder_golden.txt", vec_mem);
      clk_i = 1'b0;
      arst_n_i = 1'b0;
      sclk_i = 1'b0;
      sdi_i = 1'b0;
      sen_i = 1'b0;
      clear_status_i = 1'b0;
      tap_ack_i = 1'b0;
      rx_a_a_i = '0;
      rx_b_a_i = '0;
      rng = 32'hd53f_992e;
      errors = 0;
      chan_delay = 1;
      chan_gain = 0;
      repeat (4) @(posedge clk_i);
      arst_n_i <= 1'b1;
      for (int v = 0; v < NV; v++) begin
         n          = (1 << vec_mem[v*NF]) - 1;
         rate       = int'(vec_mem[v*NF+1]);
         check_ampl = 1'b0;
         cur_ampl   = int'(vec_mem[v*NF+2]);
         chan_delay = int'(vec_mem[v*NF+3]);
         chan_gain  = int'(vec_mem[v*NF+4]);
         exp_peak   = int'(vec_mem[v*NF+5]);
         exp_off    = int'(vec_mem[v*NF+6]);
         write_reg(REG_RATE, 32'(rate));
         write_reg(REG_AMPL, 32'(cur_ampl));
         write_reg(REG_MODE, 32'd3);
         // Degree write restarts both codes
         write_reg(REG_DEGREE, vec_mem[v*NF]);
         @(negedge clk_i);
         tap_q.delete();
         check_ampl = 1'b1;
         random_ack = (v != 0);
         // Lag 0 period still holds samples from before the restart
         for (int k = 0; k <= n; k++) begin
            get_tap(t);
            check_tap(t, k % n, k > 0);
         end
         next_lag = 1;
         if (v == 0) begin
            // Hold one tap open past two more periods
            @(negedge clk_i);
            tap_q.delete();
            hold_ack = 1'b1;
            get_tap(t);
            held_lag = next_lag;
            check_tap(t, held_lag, 1'b1);
            hold_cyc = 2 * n * (rate + 1) + n * (rate + 1) / 2;
            repeat (hold_cyc) @(posedge clk_i);
            assert (rx_overrun_o) else begin
               errors++;
               $display("ERROR %0t: overrun not set after withheld ack", $time);
            end
            @(negedge clk_i);
            hold_ack = 1'b0;
            get_tap(t);
            check_tap(t, (held_lag + 3) % n, 1'b1);
            @(posedge clk_i);
            clear_status_i <= 1'b1;
            @(posedge clk_i);
            clear_status_i <= 1'b0;
            @(posedge clk_i);
            assert (!rx_overrun_o) else begin
               errors++;
               $display("ERROR %0t: overrun still set after clear", $time);
            end
         end
         if (v == 1) begin
            // 39 bit degree frame must be dropped, lags keep counting
            send_frame({1'b0, REG_DEGREE, 32'd4}, 39);
            for (int k = 0; k < n; k++) begin
               get_tap(t);
               check_tap(t, next_lag, 1'b1);
               next_lag = (next_lag + 1) % n;
            end
         end
      end
      $display("Checks done, errors: %0d", errors);
      if (errors == 0) begin
         $display("PASS: all tests");
      end else begin
         $display("FAIL: see errors above");
      end
      $finish;
   end

endmodule

//--- tb/sounder_golden.txt
// Columns in hex: degree rate ampl delay gain_shift peak offpeak
// peak = (2^degree-1)*(ampl>>gain), offpeak = -(ampl>>gain) as 32-bit two's complement
4 3 3e8  3 2 ea6  ffffff06
5 2 800  7 1 7c00 fffffc00
6 2 1f40 14 3 f618 fffffc18
4 5 190  a 0 1770 fffffe70

//--- usrp_sounder.f
verilog/sounder_pkg.sv
verilog/serial_io.sv
verilog/sounder_ctrl.sv
verilog/pn_transmitter.sv
verilog/dac_interface.sv
verilog/pn_correlator.sv
verilog/usrp_sounder.sv
tb/tb_usrp_sounder.sv

//--- Makefile
# Verilator build and run for the channel sounder testbench

TOP = tb_usrp_sounder

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f usrp_sounder.f -Mdir obj_dir

run:
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	@if grep -q "FAIL: see errors above" sim.log; then \
		echo "Simulation failed"; exit 1; \
	fi
	@grep -q "PASS: all tests" sim.log || (echo "No pass message in log"; exit 1)

clean:
	rm -rf obj_dir sim.log
